// File: rtl/rv32_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build-time settings of the MEM stage.
// RAM depth is given as log2 of words.
// mhartid is fixed at build time.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// Data RAM depth, log2 of the number of 32-bit words.
// 10 gives 4 KiB of data memory.
`define DMEM_ADDR_BITS 10

// Value that reads back from mhartid.
// Single-hart core, so hart 0.
`define MHARTID_VALUE 32'h0000_0000

`endif

// File: rtl/rv_priv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine-mode trap and CSR encodings.
// Trap causes are 4 bits, so no interrupt flag.
// Only four CSRs exist.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rv_priv_pkg;

    // Synchronous exception causes, as in mcause.
    // Causes from earlier stages pass as raw values.
    typedef enum logic [3:0] {
        CAUSE_INSN_MISALIGNED  = 4'd0,
        CAUSE_INSN_ACCESS      = 4'd1,
        CAUSE_ILLEGAL_INSN     = 4'd2,
        CAUSE_BREAKPOINT       = 4'd3,
        CAUSE_LOAD_MISALIGNED  = 4'd4,
        CAUSE_LOAD_ACCESS      = 4'd5,
        CAUSE_STORE_MISALIGNED = 4'd6,
        CAUSE_STORE_ACCESS     = 4'd7,
        CAUSE_ECALL_M          = 4'd11
    } trap_cause_e;

    // Implemented CSR addresses.
    // Top bits 11 mark the read-only ones.
    typedef enum logic [11:0] {
        CSR_MISA     = 12'h301,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MHARTID  = 12'hF14
    } csr_addr_e;

    // CSR operation, funct3 bits 1:0.
    // 00 is unused here.
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

endpackage

// File: rtl/rv_isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I instruction word encodings.
// Only the opcodes the MEM stage acts on are named.
// Other opcodes still decode, as raw values.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rv_isa_pkg;

    // Major opcode, bits 6:2 of the instruction word.
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OTHER  = 5'b00100,
        OPC_STORE  = 5'b01000,
        OPC_SYSTEM = 5'b11100
    } opcode_e;

    // Access width of a load or store, from funct3.
    typedef enum logic [2:0] {
        MW_B  = 3'b000,
        MW_H  = 3'b001,
        MW_W  = 3'b010,
        MW_BU = 3'b100,
        MW_HU = 3'b101
    } mem_width_e;

    // funct3 of a Zicsr instruction.
    // Bit 2 picks the uimm form, bits 1:0 the operation.
    // An op of 00 is not a CSR instruction (ECALL, EBREAK, MRET).
    typedef struct packed {
        logic                 use_imm;
        rv_priv_pkg::csr_op_e op;
    } csr_funct3_t;

    // Load/store view.
    // imm_hi and rd also carry the store immediate.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        mem_width_e funct3;
        logic [4:0] rd;
        opcode_e    opcode;
        logic [1:0] quad;
    } mem_view_t;

    // SYSTEM view.
    // The CSR address is raw so unknown addresses survive decode.
    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  uimm;
        csr_funct3_t funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
        logic [1:0]  quad;
    } sys_view_t;

    // One instruction word, decoded both ways.
    // The opcode sits at the same bits in both views.
    typedef union packed {
        mem_view_t mem;
        sys_view_t sys;
    } insn_u;

endpackage

// File: rtl/data_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage-side buses to the RAM and CSR file.
// Each instance carries one of the two.
// All reads are combinational.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface data_bus_if;

    // Data RAM side.
    // Word index, byte lane data and enables.
    logic [29:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wmask;
    logic        we;

    // Read data, shared by both buses.
    logic [31:0] rdata;

    // CSR side.
    logic                 en;
    logic [11:0]          csr_addr;
    rv_priv_pkg::csr_op_e op;
    logic [31:0]          operand;
    logic                 illegal;

    modport controller (output addr, wdata, wmask, we, input rdata);
    modport memory     (input addr, wdata, wmask, we, output rdata);

    modport requester (output en, csr_addr, op, operand, input rdata, illegal);
    modport responder (input en, csr_addr, op, operand, output rdata, illegal);

endinterface

// File: rtl/mem_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEM stage with its MEM/WB barrier.
// Stall gives a bubble, record is held upstream.
// Traps kill the write of the same record.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_stage (
    input  logic                     clk,
    input  logic                     rst,

    data_bus_if.controller           dbus,
    data_bus_if.requester            csr,

    // EX/MEM record.
    input  logic                     d_valid,
    input  logic [31:1]              d_pc,
    input  rv_isa_pkg::insn_u        d_insn,
    input  logic                     d_use_rd,
    // ALU result or memory address.
    input  logic [31:0]              d_rs1_val,
    // Store data.
    input  logic [31:0]              d_rs2_val,
    input  logic                     d_trap,
    input  rv_priv_pkg::trap_cause_e d_cause,

    input  logic                     stall_mem,

    // MEM/WB record.
    output logic                     q_valid,
    output logic [31:1]              q_pc,
    output rv_isa_pkg::insn_u        q_insn,
    output logic                     q_use_rd,
    output logic [31:0]              q_rd_val,
    output logic                     q_trap,
    output rv_priv_pkg::trap_cause_e q_cause
);

    logic                     is_load;
    logic                     is_store;
    logic                     is_csr;
    logic [1:0]               byte_off;
    logic                     misaligned;
    logic [3:0]               base_mask;
    logic [31:0]              load_word;
    logic [31:0]              load_val;
    logic [31:0]              rd_val;
    logic                     trap;
    rv_priv_pkg::trap_cause_e cause;

    // Decode.
    assign is_load  = d_insn.mem.opcode == rv_isa_pkg::OPC_LOAD;
    assign is_store = d_insn.mem.opcode == rv_isa_pkg::OPC_STORE;
    // funct3 op 00 is ECALL/EBREAK/MRET, passed through.
    assign is_csr   = d_insn.sys.opcode == rv_isa_pkg::OPC_SYSTEM
                   && d_insn.sys.funct3.op != rv_priv_pkg::CSR_OP_NONE;

    assign byte_off = d_rs1_val[1:0];

    // Access size.
    // Reserved widths are handled as words.
    always_comb begin
        case (d_insn.mem.funct3)
            rv_isa_pkg::MW_B, rv_isa_pkg::MW_BU: begin
                misaligned = 1'b0;
                base_mask  = 4'b0001;
            end
            rv_isa_pkg::MW_H, rv_isa_pkg::MW_HU: begin
                misaligned = byte_off[0];
                base_mask  = 4'b0011;
            end
            default: begin
                misaligned = |byte_off;
                base_mask  = 4'b1111;
            end
        endcase
    end

    // RAM request.
    // Store data goes to its byte lane.
    assign dbus.addr  = d_rs1_val[31:2];
    assign dbus.wdata = d_rs2_val << {byte_off, 3'b000};
    assign dbus.wmask = base_mask << byte_off;
    assign dbus.we    = d_valid && is_store && !misaligned && !d_trap && !stall_mem;

    // Load data, moved down to lane 0, then extended.
    assign load_word = dbus.rdata >> {byte_off, 3'b000};

    always_comb begin
        case (d_insn.mem.funct3)
            rv_isa_pkg::MW_B:  load_val = {{24{load_word[7]}}, load_word[7:0]};
            rv_isa_pkg::MW_H:  load_val = {{16{load_word[15]}}, load_word[15:0]};
            rv_isa_pkg::MW_BU: load_val = {24'h0, load_word[7:0]};
            rv_isa_pkg::MW_HU: load_val = {16'h0, load_word[15:0]};
            default:           load_val = load_word;
        endcase
    end

    // CSR request.
    // The CSR file judges legality from these fields alone.
    assign csr.csr_addr = d_insn.sys.csr;
    assign csr.op       = d_insn.sys.funct3.op;
    assign csr.operand  = d_insn.sys.funct3.use_imm ? {27'h0, d_insn.sys.uimm} : d_rs1_val;
    assign csr.en       = d_valid && is_csr && !d_trap && !stall_mem;

    // Result mux.
    // Everything else passes the ALU result.
    always_comb begin
        if (is_load) begin
            rd_val = load_val;
        end else if (is_csr) begin
            rd_val = csr.rdata;
        end else begin
            rd_val = d_rs1_val;
        end
    end

    // Traps raised here.
    // Upstream trap wins in the barrier.
    always_comb begin
        trap  = 1'b0;
        cause = rv_priv_pkg::CAUSE_ILLEGAL_INSN;
        if (d_valid && (is_load || is_store) && misaligned) begin
            trap  = 1'b1;
            cause = is_load ? rv_priv_pkg::CAUSE_LOAD_MISALIGNED
                            : rv_priv_pkg::CAUSE_STORE_MISALIGNED;
        end else if (d_valid && is_csr && csr.illegal) begin
            trap = 1'b1;
        end
    end

    // Barrier control.
    // A stall is a full bubble, trap included.
    always_ff @(posedge clk) begin
        if (rst) begin
            q_valid <= 1'b0;
            q_trap  <= 1'b0;
        end else if (!stall_mem) begin
            q_valid <= d_valid && !d_trap && !trap;
            q_trap  <= d_trap || trap;
        end else begin
            q_valid <= 1'b0;
            q_trap  <= 1'b0;
        end
    end

    // Barrier payload.
    always_ff @(posedge clk) begin
        if (!stall_mem) begin
            q_pc     <= d_pc;
            q_insn   <= d_insn;
            q_use_rd <= d_use_rd;
            q_rd_val <= rd_val;
            q_cause  <= d_trap ? d_cause : cause;
        end
    end

    // A store that commits leaves a clean record in MEM/WB.
    assert property (@(posedge clk) disable iff (rst)
        dbus.we |=> q_valid && !q_trap);

    // One instruction drives either the RAM or the CSR file.
    assert property (@(posedge clk) disable iff (rst)
        !(csr.en && dbus.we));

endmodule

// File: rtl/csr_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine CSRs: mscratch, mtvec, mhartid, misa.
// mtvec is direct mode only.
// Illegal accesses are ignored here, trapped by the stage.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rv32_settings.svh"

module csr_file (
    input  logic          clk,
    input  logic          rst,
    data_bus_if.responder csr
);

    // RV32I: MXL = 1, I bit set.
    localparam logic [31:0] MISA_VALUE = 32'h4000_0100;

    logic [31:0] mscratch;
    logic [31:0] mtvec;
    logic        known;
    logic        read_only;
    logic        writes;
    logic [31:0] new_val;

    // Address decode and old value.
    always_comb begin
        known     = 1'b1;
        read_only = 1'b0;
        case (csr.csr_addr)
            rv_priv_pkg::CSR_MSCRATCH: begin
                csr.rdata = mscratch;
            end
            rv_priv_pkg::CSR_MTVEC: begin
                csr.rdata = mtvec;
            end
            rv_priv_pkg::CSR_MHARTID: begin
                csr.rdata = `MHARTID_VALUE;
                read_only = 1'b1;
            end
            rv_priv_pkg::CSR_MISA: begin
                csr.rdata = MISA_VALUE;
                read_only = 1'b1;
            end
            default: begin
                csr.rdata = 32'h0;
                known     = 1'b0;
            end
        endcase
    end

    // Set or clear of nothing is a pure read.
    assign writes      = csr.op == rv_priv_pkg::CSR_OP_WRITE || csr.operand != 32'h0;
    assign csr.illegal = !known || (read_only && writes);

    // Read-modify-write.
    always_comb begin
        case (csr.op)
            rv_priv_pkg::CSR_OP_SET:   new_val = csr.rdata | csr.operand;
            rv_priv_pkg::CSR_OP_CLEAR: new_val = csr.rdata & ~csr.operand;
            default:                   new_val = csr.operand;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= 32'h0;
            mtvec    <= 32'h0;
        end else if (csr.en && !csr.illegal) begin
            if (csr.csr_addr == rv_priv_pkg::CSR_MSCRATCH) begin
                mscratch <= new_val;
            end
            // Base must be word aligned.
            if (csr.csr_addr == rv_priv_pkg::CSR_MTVEC) begin
                mtvec <= {new_val[31:2], 2'b00};
            end
        end
    end

    // Registers only move on a commit strobe from the stage.
    assert property (@(posedge clk) disable iff (rst)
        !csr.en |=> $stable(mscratch) && $stable(mtvec));

endmodule

// File: rtl/data_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word RAM, combinational read, clocked write.
// Contents start undefined.
// Upper word index bits wrap.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rv32_settings.svh"

module data_ram #(
    parameter int ADDR_BITS = `DMEM_ADDR_BITS
) (
    input  logic       clk,
    data_bus_if.memory dbus
);

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [31:0]          mem [DEPTH];
    logic [ADDR_BITS-1:0] index;

    // Bits above the index are dropped.
    assign index = dbus.addr[ADDR_BITS-1:0];

    // Read is same cycle.
    assign dbus.rdata = mem[index];

    // Byte-lane write.
    // Lanes with a clear mask bit keep their old byte.
    always_ff @(posedge clk) begin
        if (dbus.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dbus.wmask[lane]) begin
                    mem[index][lane*8 +: 8] <= dbus.wdata[lane*8 +: 8];
                end
            end
        end
    end

endmodule

// File: rtl/rv32_memstage_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEM stage with its CSR file and data RAM.
// One cycle from d_ to q_, stall_mem gives a bubble.
// q_ payload is undefined until the first record.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rv32_settings.svh"

module rv32_memstage_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall_mem,

    // EX/MEM record.
    input  logic        d_valid,
    input  logic [31:1] d_pc,
    input  logic [31:0] d_insn,
    input  logic        d_use_rd,
    input  logic [31:0] d_rs1_val,
    input  logic [31:0] d_rs2_val,
    input  logic        d_trap,
    input  logic [3:0]  d_cause,

    // MEM/WB record.
    output logic        q_valid,
    output logic [31:1] q_pc,
    output logic [31:0] q_insn,
    output logic        q_use_rd,
    output logic [31:0] q_rd_val,
    output logic        q_trap,
    output logic [3:0]  q_cause
);

    data_bus_if u_dbus ();
    data_bus_if u_csr_bus ();

    mem_stage u_mem (
        .clk       (clk),
        .rst       (rst),
        .dbus      (u_dbus.controller),
        .csr       (u_csr_bus.requester),
        .d_valid   (d_valid),
        .d_pc      (d_pc),
        .d_insn    (d_insn),
        .d_use_rd  (d_use_rd),
        .d_rs1_val (d_rs1_val),
        .d_rs2_val (d_rs2_val),
        .d_trap    (d_trap),
        // Raw upstream cause, any 4-bit value.
        .d_cause   (rv_priv_pkg::trap_cause_e'(d_cause)),
        .stall_mem (stall_mem),
        .q_valid   (q_valid),
        .q_pc      (q_pc),
        .q_insn    (q_insn),
        .q_use_rd  (q_use_rd),
        .q_rd_val  (q_rd_val),
        .q_trap    (q_trap),
        .q_cause   (q_cause)
    );

    csr_file u_csr (
        .clk (clk),
        .rst (rst),
        .csr (u_csr_bus.responder)
    );

    data_ram #(
        .ADDR_BITS (`DMEM_ADDR_BITS)
    ) u_ram (
        .clk  (clk),
        .dbus (u_dbus.memory)
    );

endmodule

// File: testbench/tb_ref_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the MEM stage.
// Only a 64-word RAM window is modelled.
// Call step once per driven cycle, in order.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rv32_settings.svh"

package tb_ref_pkg;

    // EX/MEM record as driven on the top-level ports.
    typedef struct packed {
        logic              valid;
        logic [31:1]       pc;
        rv_isa_pkg::insn_u insn;
        logic              use_rd;
        logic [31:0]       rs1_val;
        logic [31:0]       rs2_val;
        logic              trap;
        logic [3:0]        cause;
    } ex_rec_t;

    // Expected MEM/WB record.
    // Payload is only compared when check_payload is set.
    typedef struct packed {
        logic                     check_payload;
        logic                     valid;
        logic                     trap;
        logic                     use_rd;
        logic [31:1]              pc;
        rv_isa_pkg::insn_u        insn;
        logic [31:0]              rd_val;
        rv_priv_pkg::trap_cause_e cause;
    } wb_exp_t;

    // Model state.
    logic [31:0] ram [64];
    logic [31:0] mscratch;
    logic [31:0] mtvec;

    function automatic void reset_model();
        mscratch = 32'h0;
        mtvec    = 32'h0;
    endfunction

    // Load result from the addressed word, funct3 as in the ISA manual.
    function automatic logic [31:0] load_value(input logic [31:0] word,
                                               input logic [1:0] off,
                                               input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        case (off)
            2'd0:    b = word[7:0];
            2'd1:    b = word[15:8];
            2'd2:    b = word[23:16];
            default: b = word[31:24];
        endcase
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b100:  return {24'h0, b};
            3'b101:  return {16'h0, h};
            default: return word;
        endcase
    endfunction

    // Zicsr access. Returns 1 for an illegal access, which changes nothing.
    function automatic logic csr_access(input logic [31:0] insn,
                                        input logic [31:0] rs1_val,
                                        output logic [31:0] old);
        logic [31:0] operand;
        logic [31:0] new_val;
        logic        known;
        logic        read_only;
        logic        writes;
        known     = 1'b1;
        read_only = 1'b0;
        operand   = insn[14] ? {27'h0, insn[19:15]} : rs1_val;
        case (insn[31:20])
            12'h340: old = mscratch;
            12'h305: old = mtvec;
            12'hF14: begin
                old       = `MHARTID_VALUE;
                read_only = 1'b1;
            end
            // MXL = 1 and the I extension.
            12'h301: begin
                old       = 32'h4000_0100;
                read_only = 1'b1;
            end
            default: begin
                old   = 32'h0;
                known = 1'b0;
            end
        endcase
        // CSRRS and CSRRC with a zero operand do not write.
        writes = insn[13:12] == 2'b01 || operand != 32'h0;
        if (!known || (read_only && writes)) begin
            return 1'b1;
        end
        case (insn[13:12])
            2'b01:   new_val = operand;
            2'b10:   new_val = old | operand;
            default: new_val = old & ~operand;
        endcase
        if (insn[31:20] == 12'h340) begin
            mscratch = new_val;
        end
        if (insn[31:20] == 12'h305) begin
            mtvec = new_val & 32'hFFFF_FFFC;
        end
        return 1'b0;
    endfunction

    // Expected result of one cycle, with the model updated for it.
    function automatic wb_exp_t step(input ex_rec_t r, input logic stall);
        wb_exp_t     e;
        logic [31:0] raw;
        logic [31:0] old;
        logic [5:0]  idx;
        logic [1:0]  off;
        logic [2:0]  f3;
        logic        misaligned;
        e = '0;
        // A stall is a bubble and the record waits upstream.
        if (stall) begin
            return e;
        end
        e.check_payload = r.valid;
        e.pc            = r.pc;
        e.insn          = r.insn;
        e.use_rd        = r.use_rd;
        if (r.trap) begin
            e.trap  = 1'b1;
            e.cause = rv_priv_pkg::trap_cause_e'(r.cause);
            return e;
        end
        if (!r.valid) begin
            return e;
        end
        raw        = r.insn;
        f3         = raw[14:12];
        idx        = r.rs1_val[7:2];
        off        = r.rs1_val[1:0];
        misaligned = (f3[1:0] == 2'b01 && off[0]) || (f3[1:0] == 2'b10 && off != 2'b00);
        e.valid    = 1'b1;
        e.rd_val   = r.rs1_val;
        case (raw[6:2])
            5'b00000: begin
                if (misaligned) begin
                    e.trap  = 1'b1;
                    e.cause = rv_priv_pkg::trap_cause_e'(4'd4);
                end else begin
                    e.rd_val = load_value(ram[idx], off, f3);
                end
            end
            5'b01000: begin
                if (misaligned) begin
                    e.trap  = 1'b1;
                    e.cause = rv_priv_pkg::trap_cause_e'(4'd6);
                end else if (f3 == 3'b000) begin
                    ram[idx][8*off +: 8] = r.rs2_val[7:0];
                end else if (f3 == 3'b001) begin
                    ram[idx][8*off +: 16] = r.rs2_val[15:0];
                end else begin
                    ram[idx] = r.rs2_val;
                end
            end
            5'b11100: begin
                // funct3 000 is not a CSR instruction and passes through.
                if (f3[1:0] != 2'b00) begin
                    if (csr_access(raw, r.rs1_val, old)) begin
                        e.trap  = 1'b1;
                        e.cause = rv_priv_pkg::trap_cause_e'(4'd2);
                    end else begin
                        e.rd_val = old;
                    end
                end
            end
            default: begin
            end
        endcase
        e.valid = !e.trap;
        return e;
    endfunction

endpackage

// File: testbench/tb_memstage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random testbench for rv32_memstage_top.
// Preloads a 64-word window, then 2000 records.
// Stops at the first mismatch.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rv32_settings.svh"

module tb_memstage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RECORDS = 2000;
    // About 2450 cycles with 15% stalls, so well over twice that.
    localparam int MAX_CYCLES  = 6000;

    logic        clk = 1'b0;
    logic        rst;
    logic        stall_mem;
    logic        d_valid;
    logic [31:1] d_pc;
    logic [31:0] d_insn;
    logic        d_use_rd;
    logic [31:0] d_rs1_val;
    logic [31:0] d_rs2_val;
    logic        d_trap;
    logic [3:0]  d_cause;
    logic        q_valid;
    logic [31:1] q_pc;
    logic [31:0] q_insn;
    logic        q_use_rd;
    logic [31:0] q_rd_val;
    logic        q_trap;
    logic [3:0]  q_cause;

    tb_ref_pkg::wb_exp_t pending;
    tb_ref_pkg::ex_rec_t rec;
    logic                have_rec;
    logic                stall;
    int                  accepted;
    int                  cycle_count = 0;

    rv32_memstage_top u_rv32_memstage_top (.*);

    always #50 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            report_failure("Timeout: the test did not finish within the cycle limit.");
        end
    end

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                     $time, what, got, expected));
        end
    endtask

    task automatic check_insn(input rv_isa_pkg::insn_u got, input rv_isa_pkg::insn_u expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch at %0d ns: q_insn is %h, expected %h",
                                     $time, got, expected));
        end
    endtask

    task automatic check_cause(input rv_priv_pkg::trap_cause_e got,
                               input rv_priv_pkg::trap_cause_e expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch at %0d ns: q_cause is %0d, expected %0d",
                                     $time, got, expected));
        end
    endtask

    task automatic check_flags(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch at %0d ns: %s is %b, expected %b",
                                     $time, what, got, expected));
        end
    endtask

    task automatic check_record(input tb_ref_pkg::wb_exp_t e);
        check_flags("q_valid", q_valid, e.valid);
        check_flags("q_trap", q_trap, e.trap);
        if (e.check_payload) begin
            check_word("q_pc", {q_pc, 1'b0}, {e.pc, 1'b0});
            check_insn(rv_isa_pkg::insn_u'(q_insn), e.insn);
            check_flags("q_use_rd", q_use_rd, e.use_rd);
        end
        if (e.trap) begin
            check_cause(rv_priv_pkg::trap_cause_e'(q_cause), e.cause);
        end
        // Trapped and bubble records carry no defined result.
        if (e.valid) begin
            check_word("q_rd_val", q_rd_val, e.rd_val);
        end
    endtask

    // Drive one cycle, then check the record sampled at this edge.
    task automatic run_cycle(input tb_ref_pkg::ex_rec_t r, input logic stall_in);
        tb_ref_pkg::wb_exp_t e;
        @(posedge clk);
        d_valid   <= r.valid;
        d_pc      <= r.pc;
        d_insn    <= r.insn;
        d_use_rd  <= r.use_rd;
        d_rs1_val <= r.rs1_val;
        d_rs2_val <= r.rs2_val;
        d_trap    <= r.trap;
        d_cause   <= r.cause;
        stall_mem <= stall_in;
        e = tb_ref_pkg::step(r, stall_in);
        @(negedge clk);
        check_record(pending);
        pending = e;
    endtask

    // Width of a load or store.
    function automatic rv_isa_pkg::mem_width_e pick_width(input logic is_load);
        case ($urandom_range(0, is_load ? 4 : 2))
            0:       return rv_isa_pkg::MW_B;
            1:       return rv_isa_pkg::MW_H;
            2:       return rv_isa_pkg::MW_W;
            3:       return rv_isa_pkg::MW_BU;
            default: return rv_isa_pkg::MW_HU;
        endcase
    endfunction

    // Address in the window, with random bits above the RAM index.
    function automatic logic [31:0] mem_address(input rv_isa_pkg::mem_width_e w);
        logic [31:0] rnd;
        logic [1:0]  off;
        rnd = $urandom();
        if (w == rv_isa_pkg::MW_B || w == rv_isa_pkg::MW_BU) begin
            off = rnd[7:6];
        end else if ($urandom_range(0, 9) == 0) begin
            // Misaligned.
            if (w == rv_isa_pkg::MW_W) begin
                off = rnd[7:6] == 2'b00 ? 2'b10 : rnd[7:6];
            end else begin
                off = {rnd[6], 1'b1};
            end
        end else begin
            off = w == rv_isa_pkg::MW_W ? 2'b00 : {rnd[6], 1'b0};
        end
        return ($urandom() << (`DMEM_ADDR_BITS + 2)) | {24'h0, rnd[5:0], off};
    endfunction

    // Known CSRs two times in three, otherwise any address.
    function automatic logic [11:0] pick_csr();
        logic [31:0] rnd;
        rnd = $urandom();
        case ($urandom_range(0, 5))
            0:       return rv_priv_pkg::CSR_MSCRATCH;
            1:       return rv_priv_pkg::CSR_MTVEC;
            2:       return rv_priv_pkg::CSR_MHARTID;
            3:       return rv_priv_pkg::CSR_MISA;
            default: return rnd[11:0];
        endcase
    endfunction

    // Opcodes outside LOAD, STORE and SYSTEM.
    function automatic rv_isa_pkg::opcode_e other_opcode();
        case ($urandom_range(0, 3))
            0:       return rv_isa_pkg::OPC_OTHER;
            1:       return rv_isa_pkg::opcode_e'(5'b01100);
            2:       return rv_isa_pkg::opcode_e'(5'b01101);
            default: return rv_isa_pkg::opcode_e'(5'b11000);
        endcase
    endfunction

    function automatic tb_ref_pkg::ex_rec_t random_record();
        tb_ref_pkg::ex_rec_t r;
        logic [31:0]         rnd;
        int                  kind;
        rnd              = $urandom();
        r.valid          = 1'b1;
        r.pc             = rnd[31:1];
        r.use_rd         = rnd[0];
        // Cause drawn apart from pc.
        rnd              = $urandom();
        r.cause          = rnd[3:0];
        r.trap           = $urandom_range(0, 99) < 5;
        r.insn           = rv_isa_pkg::insn_u'($urandom());
        r.insn.mem.quad  = 2'b11;
        r.rs1_val        = $urandom();
        r.rs2_val        = $urandom();
        kind             = $urandom_range(0, 99);
        if (kind < 55) begin
            r.insn.mem.opcode = kind < 30 ? rv_isa_pkg::OPC_LOAD : rv_isa_pkg::OPC_STORE;
            r.insn.mem.funct3 = pick_width(kind < 30);
            r.rs1_val         = mem_address(r.insn.mem.funct3);
        end else if (kind < 80) begin
            rnd                    = $urandom_range(1, 3);
            r.insn.sys.opcode      = rv_isa_pkg::OPC_SYSTEM;
            r.insn.sys.funct3.op   = rv_priv_pkg::csr_op_e'(rnd[1:0]);
            r.insn.sys.csr         = pick_csr();
            // Zero operand now and then, so read-only CSRs can be read.
            if ($urandom_range(0, 3) == 0) begin
                r.rs1_val       = 32'h0;
                r.insn.sys.uimm = 5'h0;
            end
        end else begin
            r.insn.mem.opcode = other_opcode();
        end
        return r;
    endfunction

    // SW of a random word to window word i.
    function automatic tb_ref_pkg::ex_rec_t preload_record(input int i);
        tb_ref_pkg::ex_rec_t r;
        r                 = '0;
        r.valid           = 1'b1;
        r.insn.mem.quad   = 2'b11;
        r.insn.mem.opcode = rv_isa_pkg::OPC_STORE;
        r.insn.mem.funct3 = rv_isa_pkg::MW_W;
        r.rs1_val         = i << 2;
        r.rs2_val         = $urandom();
        return r;
    endfunction

    initial begin
        void'($urandom(32'he9c9_a11e));
        rst       <= 1'b1;
        stall_mem <= 1'b0;
        d_valid   <= 1'b0;
        d_pc      <= '0;
        d_insn    <= '0;
        d_use_rd  <= 1'b0;
        d_rs1_val <= '0;
        d_rs2_val <= '0;
        d_trap    <= 1'b0;
        d_cause   <= '0;
        tb_ref_pkg::reset_model();
        pending = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Every window word gets a defined value before any load.
        for (int i = 0; i < 64; i++) begin
            run_cycle(preload_record(i), 1'b0);
        end

        // A stalled record is held and offered again.
        accepted = 0;
        have_rec = 1'b0;
        while (accepted < NUM_RECORDS) begin
            if (!have_rec) begin
                rec      = random_record();
                have_rec = 1'b1;
            end
            stall = $urandom_range(0, 99) < 15;
            run_cycle(rec, stall);
            if (!stall) begin
                have_rec = 1'b0;
                accepted++;
            end
        end

        // Idle cycle to check the last record.
        run_cycle('0, 1'b0);
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: rv32_memstage.f
+incdir+rtl
rtl/rv_priv_pkg.sv
rtl/rv_isa_pkg.sv
rtl/data_bus_if.sv
rtl/mem_stage.sv
rtl/csr_file.sv
rtl/data_ram.sv
rtl/rv32_memstage_top.sv
testbench/tb_ref_pkg.sv
testbench/tb_memstage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the MEM stage testbench with Verilator and runs it.
# The run passes only if the testbench prints its pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module tb_memstage \
    -f rv32_memstage.f \
    -Mdir obj_dir -o sim_memstage

# Keep the output even when the simulation stops with an error.
output="$(./obj_dir/sim_memstage 2>&1)" || true
echo "$output"

if grep -qxF "Done: no errors" <<< "$output"; then
    echo "Simulation passed."
    exit 0
else
    echo "Simulation failed."
    exit 1
fi
